/* source/flow_mux_pkg.sv */
package flow_mux_pkg;

  // --------------------------------------------------------------------------
  // Sizes
  // --------------------------------------------------------------------------

  // Number of push flows into the multiplexer
  localparam int num_flows = 4;

  // Payload width of every flow and of the pop port
  localparam int data_width = 8;

  // --------------------------------------------------------------------------
  // Types
  // --------------------------------------------------------------------------

  // Flow index, wide enough for num_flows entries
  // Wraps modulo num_flows because num_flows is a power of two
  typedef logic [$clog2(num_flows)-1:0] flow_idx_t;

  // Occupancy of the forward flow register
  typedef enum logic {
    reg_empty = 1'b0,
    reg_full  = 1'b1
  } reg_state_e;

endpackage

/* source/arb_if.sv */
`timescale 1ns/1ps

// Arbitration bundle between the mux core and the round-robin arbiter
interface arb_if import flow_mux_pkg::*; ();

  // One request bit per flow, driven by the core
  logic [num_flows-1:0] request;
  // Flow i would win if it requested
  logic [num_flows-1:0] can_grant;
  // One-hot winner, can_grant gated with request
  logic [num_flows-1:0] grant;
  // Move the priority pointer at the next edge
  logic                 enable_priority_update;

  // Mux core side
  modport core (
    output request,
    output enable_priority_update,
    input  can_grant,
    input  grant
  );

  // Arbiter side
  modport arb (
    input  request,
    input  enable_priority_update,
    output can_grant,
    output grant
  );

endinterface

/* source/rr_arbiter.sv */
`timescale 1ns/1ps

// Stateful round-robin arbiter
// Pointer only moves when the core says the grant was used
module rr_arbiter import flow_mux_pkg::*; (
  input logic clk,
  input logic arst_n,
  arb_if.arb  arb
);

  // --------------------------------------------------------------------------
  // Priority pointer
  // --------------------------------------------------------------------------

  // Flow with the highest priority this cycle
  flow_idx_t prio_ptr;
  // Index of the one-hot grant
  flow_idx_t grant_idx;
  // Some flow ahead in the search order already requests
  logic      taken;
  // Flow visited at each step of the search
  flow_idx_t search_idx;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      // Flow 0 is favored out of reset
      prio_ptr <= '0;
    end else if (arb.enable_priority_update) begin
      // Winner goes to the back of the line
      prio_ptr <= grant_idx + flow_idx_t'(1);
    end
  end

  // --------------------------------------------------------------------------
  // Grant logic
  // --------------------------------------------------------------------------

  // Walk upward from the pointer, wrapping around
  // A flow can win only if no flow before it in that order requests
  always_comb begin
    taken         = 1'b0;
    search_idx    = prio_ptr;
    arb.can_grant = '0;
    for (int k = 0; k < num_flows; k++) begin
      search_idx                = prio_ptr + flow_idx_t'(k);
      arb.can_grant[search_idx] = !taken;
      taken                     = taken | arb.request[search_idx];
    end
  end

  // At most one bit survives the gating
  assign arb.grant = arb.can_grant & arb.request;

  // Encode the one-hot grant for the pointer update
  always_comb begin
    grant_idx = '0;
    for (int i = 0; i < num_flows; i++) begin
      if (arb.grant[i]) begin
        grant_idx = flow_idx_t'(i);
      end
    end
  end

endmodule

/* source/flow_mux_core.sv */
`timescale 1ns/1ps

// Combinational mux core
// Requests come from push valids, the granted flow goes out unstable
module flow_mux_core import flow_mux_pkg::*; (
  arb_if.core                                arb,
  input  logic [num_flows-1:0]               push_valid,
  input  logic [num_flows-1:0][data_width-1:0] push_data,
  output logic [num_flows-1:0]               push_ready,
  input  logic                               pop_ready,
  output logic                               pop_valid_unstable,
  output logic [data_width-1:0]              pop_data_unstable
);

  // --------------------------------------------------------------------------
  // Arbitration requests
  // --------------------------------------------------------------------------

  // Every valid flow competes
  assign arb.request = push_valid;

  // Any valid flow makes the pop valid
  // Valid can drop if a flow withdraws, hence unstable
  assign pop_valid_unstable = |push_valid;

  // Pointer moves only on a real transfer
  // Grant is nonzero whenever some flow is valid
  assign arb.enable_priority_update = pop_valid_unstable && pop_ready;

  // --------------------------------------------------------------------------
  // Data path
  // --------------------------------------------------------------------------

  // AND-OR select on the one-hot grant
  always_comb begin
    pop_data_unstable = '0;
    for (int i = 0; i < num_flows; i++) begin
      if (arb.grant[i]) begin
        pop_data_unstable = pop_data_unstable | push_data[i];
      end
    end
  end

  // --------------------------------------------------------------------------
  // Push back-pressure
  // --------------------------------------------------------------------------

  // Only the winner sees ready, and only when downstream takes it
  assign push_ready = arb.grant & {num_flows{pop_ready}};

endmodule

/* source/flow_reg_fwd.sv */
`timescale 1ns/1ps

// Forward flow register
// One entry, pop valid and data come straight from flops
module flow_reg_fwd import flow_mux_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  push_valid,
  input  logic [data_width-1:0] push_data,
  output logic                  push_ready,
  output logic                  pop_valid,
  output logic [data_width-1:0] pop_data,
  input  logic                  pop_ready
);

  // Occupancy of the single entry
  reg_state_e            state;
  // Payload of the held word
  logic [data_width-1:0] data_q;

  // Accept on this edge
  logic push_xfer;
  // Held word leaves on this edge
  logic pop_xfer;

  // Room when empty, or when the held word leaves this cycle
  // Combinational path from pop_ready back upstream
  assign push_ready = (state == reg_empty) || pop_ready;

  assign pop_valid = (state == reg_full);
  assign pop_data  = data_q;

  assign push_xfer = push_valid && push_ready;
  assign pop_xfer  = pop_valid && pop_ready;

  // --------------------------------------------------------------------------
  // State and payload
  // --------------------------------------------------------------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= reg_empty;
    end else if (push_xfer) begin
      // New word replaces or fills the entry
      state <= reg_full;
    end else if (pop_xfer) begin
      // Drained with nothing behind it
      state <= reg_empty;
    end
  end

  // Payload only changes on accept
  always_ff @(posedge clk) begin
    if (push_xfer) begin
      data_q <= push_data;
    end
  end

endmodule

/* source/flow_mux_stable.sv */
`timescale 1ns/1ps

// Stable multiplexer
// Mux core followed by a forward register on the pop side
module flow_mux_stable import flow_mux_pkg::*; (
  input  logic                                 clk,
  input  logic                                 arst_n,
  arb_if.core                                  arb,
  input  logic [num_flows-1:0]                 push_valid,
  input  logic [num_flows-1:0][data_width-1:0] push_data,
  output logic [num_flows-1:0]                 push_ready,
  input  logic                                 pop_ready,
  output logic                                 pop_valid,
  output logic [data_width-1:0]                pop_data
);

  // --------------------------------------------------------------------------
  // Internal handshake between core and register
  // --------------------------------------------------------------------------

  logic                  internal_valid;
  logic [data_width-1:0] internal_data;
  // Register has room for the core's word
  logic                  internal_ready;

  // Arbitration and data select
  flow_mux_core u_core (
    .arb                (arb),
    .push_valid         (push_valid),
    .push_data          (push_data),
    .push_ready         (push_ready),
    .pop_ready          (internal_ready),
    .pop_valid_unstable (internal_valid),
    .pop_data_unstable  (internal_data)
  );

  // Holds the pop side steady under back-pressure
  flow_reg_fwd u_reg (
    .clk        (clk),
    .arst_n     (arst_n),
    .push_valid (internal_valid),
    .push_data  (internal_data),
    .push_ready (internal_ready),
    .pop_valid  (pop_valid),
    .pop_data   (pop_data),
    .pop_ready  (pop_ready)
  );

endmodule

/* source/flow_mux_top.sv */
`timescale 1ns/1ps

// Top level of the four-flow stable multiplexer
// Push word accepted at edge N is valid at pop after edge N
module flow_mux_top import flow_mux_pkg::*; (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  logic [num_flows-1:0]                 push_valid,
  input  logic [num_flows-1:0][data_width-1:0] push_data,
  output logic [num_flows-1:0]                 push_ready,
  output logic                                 pop_valid,
  output logic [data_width-1:0]                pop_data,
  input  logic                                 pop_ready
);

  // Request and grant bundle
  arb_if arb_bus ();

  // Round-robin priority state
  rr_arbiter u_arb (
    .clk    (clk),
    .arst_n (arst_n),
    .arb    (arb_bus.arb)
  );

  // Core plus forward register
  flow_mux_stable u_stable (
    .clk        (clk),
    .arst_n     (arst_n),
    .arb        (arb_bus.core),
    .push_valid (push_valid),
    .push_data  (push_data),
    .push_ready (push_ready),
    .pop_ready  (pop_ready),
    .pop_valid  (pop_valid),
    .pop_data   (pop_data)
  );

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ps

// Free-running testbench clock
// 4 ns period, first rising edge at 2 ns
module tb_clock_gen (
  output logic clk
);

  localparam int half_period_ns = 2;

  initial begin
    clk = 1'b0;
    forever begin
      #(half_period_ns) clk = ~clk;
    end
  end

endmodule

/* dv/flow_mux_properties.sv */
`timescale 1ns/1ps

// Concurrent checks on the top-level ports of the stable multiplexer
module flow_mux_properties import flow_mux_pkg::*; (
  input logic                  clk,
  input logic                  arst_n,
  input logic [num_flows-1:0]  push_ready,
  input logic                  pop_valid,
  input logic [data_width-1:0] pop_data,
  input logic                  pop_ready
);

  // ---------------------------------------------------------------------------
  // Push side
  // ---------------------------------------------------------------------------

  // Only the granted flow may see ready
  one_push_ready: assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0(push_ready))
    else $error("more than one push_ready bit high");

  // ---------------------------------------------------------------------------
  // Pop side
  // ---------------------------------------------------------------------------

  // Held word may not move or vanish under back-pressure
  pop_stable: assert property (@(posedge clk) disable iff (!arst_n)
    pop_valid && !pop_ready |=> pop_valid && $stable(pop_data))
    else $error("pop word changed while stalled");

  // Nothing leaves while reset is applied
  pop_idle_in_reset: assert property (@(posedge clk) !arst_n |-> !pop_valid)
    else $error("pop_valid high during reset");

endmodule

/* dv/flow_mux_tb.sv */
`timescale 1ns/1ps

module flow_mux_tb import flow_mux_pkg::*; ();

  localparam int reset_cycles = 10;
  // Random mix, heavy back-pressure, full throughput
  localparam int mixed_cycles    = 300;
  localparam int stall_cycles    = 300;
  localparam int streaming_cycles = 100;
  localparam int total_cycles =
    reset_cycles + 1 + mixed_cycles + stall_cycles + streaming_cycles;

  logic                                 clk;
  logic                                 arst_n;
  logic [num_flows-1:0]                 push_valid;
  logic [num_flows-1:0][data_width-1:0] push_data;
  logic [num_flows-1:0]                 push_ready;
  logic                                 pop_valid;
  logic [data_width-1:0]                pop_data;
  logic                                 pop_ready;

  integer seed;
  int     error_count;

  // Reference model of the round-robin pointer and the one-entry register
  int                    model_ptr;
  logic                  exp_full;
  logic [data_width-1:0] exp_data;
  // Flows that transferred at the last edge
  logic [num_flows-1:0]  took;
  // Flow the model accepted in the previous streaming cycle or -1 before the first
  int                    last_flow;

  tb_clock_gen clk_gen (.clk(clk));

  flow_mux_top uut (.*);

  bind flow_mux_top flow_mux_properties u_props (
    .clk        (clk),
    .arst_n     (arst_n),
    .push_ready (push_ready),
    .pop_valid  (pop_valid),
    .pop_data   (pop_data),
    .pop_ready  (pop_ready)
  );

  // ---------------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------------

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("error %s expected %0h actual %0h", name, expected, actual);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // First valid flow at or after the pointer with wrap, or -1 if none
  function automatic int pick_flow(input logic [num_flows-1:0] valid, input int start);
    int idx;
    for (int k = 0; k < num_flows; k++) begin
      idx = (start + k) % num_flows;
      if (valid[idx]) return idx;
    end
    return -1;
  endfunction

  // Position of the high bit in a one-hot ready vector
  function automatic int ready_index(input logic [num_flows-1:0] ready);
    for (int i = 0; i < num_flows; i++) begin
      if (ready[i]) return i;
    end
    return -1;
  endfunction

  // New stimulus on the falling edge, then checks and the model update
  // before the rising edge
  task automatic run_cycle(input int phase);
    int                   rnd;
    int                   winner;
    logic                 accept;
    logic [num_flows-1:0] exp_ready;
    @(negedge clk);
    for (int i = 0; i < num_flows; i++) begin
      // A flow holds its word until the handshake completes
      if (!push_valid[i] || took[i]) begin
        rnd           = $random(seed);
        push_valid[i] = (phase == 2) ? 1'b1 : (rnd[1:0] != 2'b00);
        rnd           = $random(seed);
        push_data[i]  = rnd[data_width-1:0];
      end
    end
    rnd = $random(seed);
    case (phase)
      0:       pop_ready = rnd[0];
      1:       pop_ready = (rnd[2:0] == 3'b000);
      default: pop_ready = 1'b1;
    endcase
    #1;
    winner    = pick_flow(push_valid, model_ptr);
    accept    = (winner >= 0) && (!exp_full || pop_ready);
    exp_ready = '0;
    if (accept) exp_ready[winner] = 1'b1;
    check_value("push_ready", 32'(exp_ready), 32'(push_ready));
    check_value("pop_valid", 32'(exp_full), 32'(pop_valid));
    if (exp_full) begin
      check_value("pop_data", 32'(exp_data), 32'(pop_data));
    end
    if (phase == 2) begin
      check_value("throughput_accept", 32'd1, 32'(|push_ready));
      if (last_flow >= 0) begin
        check_value("throughput_order", 32'((last_flow + 1) % num_flows),
                    32'(ready_index(push_ready)));
      end
      last_flow = winner;
    end
    // Model state after the coming rising edge
    if (accept) begin
      exp_full  = 1'b1;
      exp_data  = push_data[winner];
      model_ptr = (winner + 1) % num_flows;
    end else if (exp_full && pop_ready) begin
      exp_full = 1'b0;
    end
    took = exp_ready;
  endtask

  // ---------------------------------------------------------------------------
  // Main sequence
  // ---------------------------------------------------------------------------

  initial begin
    seed        = 32'h573b_f04e;
    error_count = 0;
    arst_n      = 1'b0;
    push_valid  = '0;
    push_data   = '0;
    pop_ready   = 1'b0;
    model_ptr   = 0;
    exp_full    = 1'b0;
    exp_data    = '0;
    took        = '0;
    last_flow   = -1;
    // Outputs idle on every edge while reset is held
    repeat (reset_cycles) begin
      @(posedge clk);
      #1;
      check_value("reset_pop_valid", 32'd0, 32'(pop_valid));
      check_value("reset_push_ready", 32'd0, 32'(push_ready));
    end
    @(negedge clk);
    arst_n = 1'b1;
    // Still idle after the first edge out of reset
    @(posedge clk);
    #1;
    check_value("post_reset_pop_valid", 32'd0, 32'(pop_valid));
    check_value("post_reset_push_ready", 32'd0, 32'(push_ready));
    repeat (mixed_cycles) run_cycle(0);
    repeat (stall_cycles) run_cycle(1);
    repeat (streaming_cycles) run_cycle(2);
    if (error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Twice the nominal run length at 4 ns per cycle
  initial begin
    #(total_cycles * 4 * 2);
    $display("timeout: the test sequence did not finish in time");
    $display("SOME TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

/* src.f */
source/flow_mux_pkg.sv
source/arb_if.sv
source/rr_arbiter.sv
source/flow_mux_core.sv
source/flow_reg_fwd.sv
source/flow_mux_stable.sv
source/flow_mux_top.sv
dv/tb_clock_gen.sv
dv/flow_mux_properties.sv
dv/flow_mux_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the flow mux testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f src.f --top-module flow_mux_tb -Mdir obj_dir -o flow_mux_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/flow_mux_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  echo "result: fail"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulator exited with status $sim_status"
  exit 1
fi
echo "result: pass"
exit 0
